// File: apb_pkg.sv
`default_nettype none

package apb_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_resp_t;

    // line L word k at base + 16L + 4k, lowest byte in bits 7:0
    localparam apb_addr_t line_words_base = 8'h00;
    localparam apb_addr_t status_addr     = 8'h40;

    // status word fields
    localparam int status_valid_lsb = 0;
    localparam int status_bip_lsb   = 8;

endpackage

`default_nettype wire

// File: byte_rotator.sv
`timescale 1ns/100ps
`default_nettype none

module byte_rotator (
    input  fetch_pkg::line_t [fetch_pkg::num_lines-1:0] lines,
    input  fetch_pkg::bip_t                             offset,
    output fetch_pkg::packet_t                          packet
);

    ////////////////////////////////////////
    //         ring rotation
    ////////////////////////////////////////

    // line 0 in the low bytes, so ring byte b sits at bits 8b+7:8b
    logic [fetch_pkg::ring_bytes*8-1:0] stage [$bits(fetch_pkg::bip_t)+1];

    assign stage[0] = lines;

    // stage s rotates down by 2^s bytes when offset bit s is set
    for (genvar s = 0; s < $bits(fetch_pkg::bip_t); s++) begin : g_stage
        assign stage[s+1] = offset[s] ?
            {stage[s][(8 << s)-1:0], stage[s][fetch_pkg::ring_bytes*8-1:(8 << s)]} :
            stage[s];
    end

    // packet byte i is ring byte (offset + i) mod 64
    assign packet = stage[$bits(fetch_pkg::bip_t)][fetch_pkg::line_bytes*8-1:0];

endmodule

`default_nettype wire

// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    ////////////////////////////////////////
    //         buffer geometry
    ////////////////////////////////////////

    localparam int num_lines  = 4;
    localparam int line_bytes = 16;
    localparam int ring_bytes = 64;

    ////////////////////////////////////////
    //         vector types
    ////////////////////////////////////////

    // byte index into the 64-byte ring
    typedef logic [5:0] bip_t;

    // line number, top two bits of a bip
    typedef logic [1:0] line_idx_t;

    // instruction length, 0 to 16 bytes
    typedef logic [4:0] byte_len_t;

    // byte i in bits 8i+7:8i
    typedef logic [line_bytes*8-1:0] line_t;
    typedef logic [line_bytes*8-1:0] packet_t;

    ////////////////////////////////////////
    //         grouped signals
    ////////////////////////////////////////

    typedef struct packed {
        logic valid;
        bip_t target;
    } redirect_t;

    typedef struct packed {
        logic      stall;
        byte_len_t length;
    } decode_resp_t;

    // line given back to the fill side
    typedef struct packed {
        logic      valid;
        line_idx_t line;
    } release_t;

endpackage

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  fetch_pkg::redirect_t                        init_redir,
    input  fetch_pkg::redirect_t                        resteer_redir,
    input  fetch_pkg::redirect_t                        bp_redir,
    input  fetch_pkg::decode_resp_t                     decode_resp,
    input  fetch_pkg::line_t [fetch_pkg::num_lines-1:0] lines,
    input  logic [fetch_pkg::num_lines-1:0]             line_valid,
    output fetch_pkg::packet_t                          packet,
    output logic                                        packet_valid,
    output fetch_pkg::bip_t                             bip,
    output fetch_pkg::bip_t                             next_bip,
    output fetch_pkg::release_t                         rel,
    output logic                                        flush
);

    fetch_pkg::redirect_t redir;
    fetch_pkg::line_idx_t cur_line;
    fetch_pkg::line_idx_t nxt_line;
    fetch_pkg::line_idx_t new_line;
    logic                 lines_ready;
    logic                 accept;

    ////////////////////////////////////////
    //         redirect and packet
    ////////////////////////////////////////

    redirect_select u_redir (
        .init_redir    (init_redir),
        .resteer_redir (resteer_redir),
        .bp_redir      (bp_redir),
        .redir         (redir)
    );

    byte_rotator u_rot (
        .lines  (lines),
        .offset (bip),
        .packet (packet)
    );

    ////////////////////////////////////////
    //         packet validity
    ////////////////////////////////////////

    // packet spans the line of bip and the one after it
    assign cur_line = bip[5:4];
    assign nxt_line = cur_line + 2'd1;

    assign lines_ready = line_valid[cur_line] & line_valid[nxt_line];

    // a redirect kills the packet in its own cycle
    assign packet_valid = lines_ready & ~redir.valid;

    assign accept = packet_valid & ~decode_resp.stall;

    ////////////////////////////////////////
    //         fetch pointer
    ////////////////////////////////////////

    // wraps mod 64 through the 6-bit sum
    assign next_bip = bip + fetch_pkg::bip_t'(decode_resp.length);
    assign new_line = next_bip[5:4];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bip <= '0;
        end else if (redir.valid) begin
            // taken even under stall
            bip <= redir.target;
        end else if (accept) begin
            bip <= next_bip;
        end
    end

    ////////////////////////////////////////
    //         line release and flush
    ////////////////////////////////////////

    // at most 16 bytes per step, so only the current line can be left
    assign rel.valid = accept & (new_line != cur_line);
    assign rel.line  = cur_line;

    assign flush = redir.valid;

endmodule

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  apb_pkg::apb_req_t       apb_req,
    output apb_pkg::apb_resp_t      apb_resp,
    input  fetch_pkg::redirect_t    init_redir,
    input  fetch_pkg::redirect_t    resteer_redir,
    input  fetch_pkg::redirect_t    bp_redir,
    input  fetch_pkg::decode_resp_t decode_resp,
    output fetch_pkg::packet_t      packet,
    output logic                    packet_valid,
    output fetch_pkg::bip_t         bip,
    output fetch_pkg::bip_t         next_bip
);

    fetch_pkg::line_t [fetch_pkg::num_lines-1:0] lines;
    logic [fetch_pkg::num_lines-1:0]             line_valid;
    fetch_pkg::release_t                         rel;
    logic                                        flush;

    ////////////////////////////////////////
    //         instruction buffer
    ////////////////////////////////////////

    ibuf_lines u_ibuf (
        .clk        (clk),
        .arst_n     (arst_n),
        .apb_req    (apb_req),
        .apb_resp   (apb_resp),
        .rel        (rel),
        .flush      (flush),
        .bip        (bip),
        .lines      (lines),
        .line_valid (line_valid)
    );

    ////////////////////////////////////////
    //         fetch pointer and aligner
    ////////////////////////////////////////

    fetch_stage u_fetch (
        .clk           (clk),
        .arst_n        (arst_n),
        .init_redir    (init_redir),
        .resteer_redir (resteer_redir),
        .bp_redir      (bp_redir),
        .decode_resp   (decode_resp),
        .lines         (lines),
        .line_valid    (line_valid),
        .packet        (packet),
        .packet_valid  (packet_valid),
        .bip           (bip),
        .next_bip      (next_bip),
        .rel           (rel),
        .flush         (flush)
    );

endmodule

`default_nettype wire

// File: ibuf_lines.sv
`timescale 1ns/100ps
`default_nettype none

module ibuf_lines (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  apb_pkg::apb_req_t                             apb_req,
    output apb_pkg::apb_resp_t                            apb_resp,
    input  fetch_pkg::release_t                           rel,
    input  logic                                          flush,
    input  fetch_pkg::bip_t                               bip,
    output fetch_pkg::line_t [fetch_pkg::num_lines-1:0]   lines,
    output logic [fetch_pkg::num_lines-1:0]               line_valid
);

    ////////////////////////////////////////
    //         APB address decode
    ////////////////////////////////////////

    apb_pkg::apb_addr_t   line_off;
    fetch_pkg::line_idx_t wr_line;
    logic [1:0]           wr_word;
    logic                 access;
    logic                 is_line;
    logic                 is_status;
    logic                 line_wr_ok;
    logic                 last_word;

    // transfer completes in the access cycle, no wait states
    assign access = apb_req.psel & apb_req.penable;

    assign line_off  = apb_req.paddr - apb_pkg::line_words_base;
    assign is_line   = apb_req.paddr < apb_pkg::status_addr;
    assign is_status = apb_req.paddr == apb_pkg::status_addr;

    // 16 bytes per line, 4 bytes per word
    assign wr_line = line_off[5:4];
    assign wr_word = line_off[3:2];

    // only an empty line takes data
    assign line_wr_ok = access & apb_req.pwrite & is_line & ~line_valid[wr_line];
    assign last_word  = wr_word == 2'd3;

    ////////////////////////////////////////
    //         response
    ////////////////////////////////////////

    always_comb begin
        apb_resp.pready  = 1'b1;
        apb_resp.pslverr = 1'b0;
        apb_resp.prdata  = '0;
        if (access) begin
            if (is_status && !apb_req.pwrite) begin
                apb_resp.prdata[apb_pkg::status_valid_lsb +: fetch_pkg::num_lines] =
                    line_valid;
                apb_resp.prdata[apb_pkg::status_bip_lsb +: $bits(fetch_pkg::bip_t)] = bip;
            end else if (!line_wr_ok) begin
                // line reads, full lines, status writes, holes above status
                apb_resp.pslverr = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    //         line storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (line_wr_ok && !flush) begin
            lines[wr_line][wr_word*$bits(apb_pkg::apb_data_t) +: $bits(apb_pkg::apb_data_t)] <=
                apb_req.pwdata;
        end
    end

    ////////////////////////////////////////
    //         valid bits
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_valid <= '0;
        end else if (flush) begin
            // redirect drops the whole buffer, pending fills included
            line_valid <= '0;
        end else begin
            if (rel.valid) begin
                line_valid[rel.line] <= 1'b0;
            end
            // word 3 closes the line
            if (line_wr_ok && last_word) begin
                line_valid[wr_line] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: project.f
fetch_pkg.sv
apb_pkg.sv
redirect_select.sv
byte_rotator.sv
ibuf_lines.sv
fetch_stage.sv
fetch_top.sv
tb_fetch_top.sv

// File: redirect_select.sv
`timescale 1ns/100ps
`default_nettype none

module redirect_select (
    input  fetch_pkg::redirect_t init_redir,
    input  fetch_pkg::redirect_t resteer_redir,
    input  fetch_pkg::redirect_t bp_redir,
    output fetch_pkg::redirect_t redir
);

    // init beats resteer, resteer beats branch
    always_comb begin
        redir.valid = init_redir.valid | resteer_redir.valid | bp_redir.valid;
        if (init_redir.valid) begin
            redir.target = init_redir.target;
        end else if (resteer_redir.valid) begin
            redir.target = resteer_redir.target;
        end else if (bp_redir.valid) begin
            redir.target = bp_redir.target;
        end else begin
            // nothing pending, target unused
            redir.target = '0;
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build the fetch aligner testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_fetch_top -f project.f -o tb_fetch_top \
    && ./obj_dir/tb_fetch_top | tee /dev/stderr | grep -q "Verification passed" \
    && echo "simulation run passed" \
    || { echo "simulation run failed"; exit 1; }

// File: tb_fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_top;

    localparam int clk_half     = 4;
    localparam int sample_delay = 2;
    // about four times the cycles the directed tests take
    localparam int max_cycles   = 4000;

    logic                    clk;
    logic                    arst_n;
    apb_pkg::apb_req_t       apb_req;
    apb_pkg::apb_resp_t      apb_resp;
    fetch_pkg::redirect_t    init_redir;
    fetch_pkg::redirect_t    resteer_redir;
    fetch_pkg::redirect_t    bp_redir;
    fetch_pkg::decode_resp_t decode_resp;
    fetch_pkg::packet_t      packet;
    logic                    packet_valid;
    fetch_pkg::bip_t         bip;
    fetch_pkg::bip_t         next_bip;

    // byte model of the ring, expected pointer and line valid bits
    logic [7:0]                      ring_model [fetch_pkg::ring_bytes];
    fetch_pkg::bip_t                 exp_bip;
    logic [fetch_pkg::num_lines-1:0] exp_valid;
    int                              cycles;

    fetch_top u_fetch_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .apb_req       (apb_req),
        .apb_resp      (apb_resp),
        .init_redir    (init_redir),
        .resteer_redir (resteer_redir),
        .bp_redir      (bp_redir),
        .decode_resp   (decode_resp),
        .packet        (packet),
        .packet_valid  (packet_valid),
        .bip           (bip),
        .next_bip      (next_bip)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    initial cycles = 0;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            fail_run();
        end
    end

    ////////////////////////////////////////
    //         compare tasks
    ////////////////////////////////////////

    task automatic fail_run();
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_packet(input fetch_pkg::packet_t got, input fetch_pkg::packet_t exp,
                                input string what);
        if (got !== exp) begin
            $display("error %0t: %s got %h expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bip(input fetch_pkg::bip_t got, input fetch_pkg::bip_t exp,
                             input string what);
        if (got !== exp) begin
            $display("error %0t: %s got %0d expected %0d", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_word(input apb_pkg::apb_data_t got, input apb_pkg::apb_data_t exp,
                              input string what);
        if (got !== exp) begin
            $display("error %0t: %s got %h expected %h", $time, what, got, exp);
            fail_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error %0t: %s got %b expected %b", $time, what, got, exp);
            fail_run();
        end
    endtask

    ////////////////////////////////////////
    //         reference model
    ////////////////////////////////////////

    // 16 bytes from the ring starting at start and wrapping at 64
    function automatic fetch_pkg::packet_t model_packet(input fetch_pkg::bip_t start);
        fetch_pkg::packet_t p;
        fetch_pkg::bip_t    idx;
        for (int i = 0; i < fetch_pkg::line_bytes; i++) begin
            idx = start + fetch_pkg::bip_t'(i);
            p[8*i +: 8] = ring_model[idx];
        end
        return p;
    endfunction

    function automatic logic exp_ready();
        fetch_pkg::line_idx_t cl;
        fetch_pkg::line_idx_t nl;
        cl = exp_bip[5:4];
        nl = cl + 2'd1;
        return exp_valid[cl] & exp_valid[nl];
    endfunction

    function automatic apb_pkg::apb_data_t status_word(input fetch_pkg::bip_t b,
                                                       input logic [3:0] v);
        apb_pkg::apb_data_t w;
        w = '0;
        w[3:0] = v;
        w[13:8] = b;
        return w;
    endfunction

    ////////////////////////////////////////
    //         bus and decode drivers
    ////////////////////////////////////////

    task automatic apb_transfer(input logic wr, input apb_pkg::apb_addr_t addr,
                                input apb_pkg::apb_data_t wdata,
                                output apb_pkg::apb_data_t rdata, output logic err);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #sample_delay;
        rdata = apb_resp.prdata;
        err   = apb_resp.pslverr;
        check_flag(apb_resp.pready, 1'b1, "pready in access cycle");
        // access cycle ends here
        @(posedge clk);
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic write_line_word(input fetch_pkg::line_idx_t l, input int k);
        apb_pkg::apb_data_t w;
        apb_pkg::apb_data_t rdata;
        apb_pkg::apb_addr_t addr;
        fetch_pkg::bip_t    idx;
        logic               err;
        w = $urandom;
        addr = apb_pkg::apb_addr_t'(16 * l + 4 * k);
        apb_transfer(1'b1, addr, w, rdata, err);
        check_flag(err, 1'b0, "pslverr on line write");
        for (int b = 0; b < 4; b++) begin
            idx = fetch_pkg::bip_t'(16 * l + 4 * k + b);
            ring_model[idx] = w[8*b +: 8];
        end
        if (k == 3) begin
            exp_valid[l] = 1'b1;
        end
    endtask

    task automatic fill_line(input fetch_pkg::line_idx_t l);
        for (int k = 0; k < 4; k++) begin
            write_line_word(l, k);
        end
    endtask

    task automatic check_status();
        apb_pkg::apb_data_t rdata;
        logic               err;
        apb_transfer(1'b0, apb_pkg::status_addr, '0, rdata, err);
        check_flag(err, 1'b0, "pslverr on status read");
        check_word(rdata, status_word(exp_bip, exp_valid), "status word");
    endtask

    // srcs bit 2 init, bit 1 resteer, bit 0 branch
    task automatic redirect(input logic [2:0] srcs, input fetch_pkg::bip_t init_t,
                            input fetch_pkg::bip_t res_t, input fetch_pkg::bip_t bp_t);
        @(negedge clk);
        init_redir.valid     = srcs[2];
        init_redir.target    = init_t;
        resteer_redir.valid  = srcs[1];
        resteer_redir.target = res_t;
        bp_redir.valid       = srcs[0];
        bp_redir.target      = bp_t;
        #sample_delay;
        if (srcs != 3'b000) begin
            check_flag(packet_valid, 1'b0, "packet_valid in redirect cycle");
        end else begin
            check_flag(packet_valid, exp_ready(), "packet_valid without redirect");
        end
        @(posedge clk);
        if (srcs[2]) begin
            exp_bip = init_t;
        end else if (srcs[1]) begin
            exp_bip = res_t;
        end else if (srcs[0]) begin
            exp_bip = bp_t;
        end
        if (srcs != 3'b000) begin
            exp_valid = '0;
        end
        @(negedge clk);
        init_redir    = '0;
        resteer_redir = '0;
        bp_redir      = '0;
        check_bip(bip, exp_bip, "bip after redirect");
    endtask

    task automatic decode_step(input logic stall, input fetch_pkg::byte_len_t len);
        fetch_pkg::bip_t nb;
        logic            ready;
        @(negedge clk);
        decode_resp.stall  = stall;
        decode_resp.length = len;
        #sample_delay;
        ready = exp_ready();
        nb = exp_bip + fetch_pkg::bip_t'(len);
        check_flag(packet_valid, ready, "packet_valid");
        check_bip(bip, exp_bip, "bip");
        check_bip(next_bip, nb, "next_bip");
        if (ready) begin
            check_packet(packet, model_packet(exp_bip), "packet");
        end
        @(posedge clk);
        if (ready && !stall) begin
            // leaving a line gives it back
            if (nb[5:4] != exp_bip[5:4]) begin
                exp_valid[exp_bip[5:4]] = 1'b0;
            end
            exp_bip = nb;
        end
    endtask

    task automatic hold_decode();
        @(negedge clk);
        decode_resp.stall = 1'b1;
    endtask

    task automatic refill_invalid();
        for (int i = 0; i < fetch_pkg::num_lines; i++) begin
            if (!exp_valid[i]) begin
                fill_line(fetch_pkg::line_idx_t'(i));
            end
        end
    endtask

    ////////////////////////////////////////
    //         directed tests
    ////////////////////////////////////////

    task automatic test_fill_status();
        apb_pkg::apb_data_t rdata;
        logic               err;
        fill_line(2'd0);
        fill_line(2'd1);
        check_status();
        apb_transfer(1'b1, 8'h00, $urandom, rdata, err);
        check_flag(err, 1'b1, "pslverr on write to valid line");
        apb_transfer(1'b0, 8'h04, '0, rdata, err);
        check_flag(err, 1'b1, "pslverr on line read");
        check_word(rdata, '0, "line read data");
        apb_transfer(1'b1, apb_pkg::status_addr, $urandom, rdata, err);
        check_flag(err, 1'b1, "pslverr on status write");
        apb_transfer(1'b0, 8'h44, '0, rdata, err);
        check_flag(err, 1'b1, "pslverr above status");
        // rejected write left line 0 alone
        check_flag(packet_valid, 1'b1, "packet_valid after fill");
        check_packet(packet, model_packet(exp_bip), "packet after rejected write");
    endtask

    task automatic test_extraction();
        fetch_pkg::bip_t      t;
        fetch_pkg::line_idx_t l;
        for (int n = 0; n < 8; n++) begin
            // upper half wraps from line 3 into line 0
            if (n < 4) begin
                t = fetch_pkg::bip_t'($urandom_range(0, 63));
            end else begin
                t = fetch_pkg::bip_t'($urandom_range(50, 63));
            end
            redirect(3'b100, t, '0, '0);
            l = t[5:4];
            fill_line(l);
            fill_line(fetch_pkg::line_idx_t'(l + 2'd1));
            check_flag(packet_valid, 1'b1, "packet_valid at target");
            check_packet(packet, model_packet(t), "packet at target");
        end
    endtask

    task automatic test_partial();
        fetch_pkg::bip_t      t;
        fetch_pkg::line_idx_t l;
        fetch_pkg::line_idx_t nl;
        t = fetch_pkg::bip_t'($urandom_range(0, 63));
        redirect(3'b100, t, '0, '0);
        l = t[5:4];
        nl = l + 2'd1;
        fill_line(l);
        check_flag(packet_valid, 1'b0, "packet_valid with next line empty");
        for (int k = 0; k < 3; k++) begin
            write_line_word(nl, k);
        end
        check_flag(packet_valid, 1'b0, "packet_valid before last word");
        write_line_word(nl, 3);
        check_flag(packet_valid, 1'b1, "packet_valid after last word");
        check_packet(packet, model_packet(t), "packet after partial fill");
    endtask

    task automatic test_advance();
        redirect(3'b100, '0, '0, '0);
        refill_invalid();
        for (int n = 0; n < 80; n++) begin
            if (!exp_ready()) begin
                hold_decode();
                check_status();
                refill_invalid();
            end
            decode_step($urandom_range(0, 3) == 0,
                        fetch_pkg::byte_len_t'($urandom_range(1, 16)));
        end
        hold_decode();
        check_status();
    endtask

    task automatic test_redirect_priority();
        fetch_pkg::line_idx_t l;
        logic [2:0]           srcs;
        for (int c = 0; c < 8; c++) begin
            l = exp_bip[5:4];
            if (!exp_valid[l]) begin
                fill_line(l);
            end
            if (!exp_valid[fetch_pkg::line_idx_t'(l + 2'd1)]) begin
                fill_line(fetch_pkg::line_idx_t'(l + 2'd1));
            end
            srcs = c[2:0];
            redirect(srcs, fetch_pkg::bip_t'($urandom), fetch_pkg::bip_t'($urandom),
                     fetch_pkg::bip_t'($urandom));
            check_status();
        end
    endtask

    initial begin
        void'($urandom(32'hcc51976e));
        arst_n             = 1'b0;
        apb_req            = '0;
        init_redir         = '0;
        resteer_redir      = '0;
        bp_redir           = '0;
        decode_resp.stall  = 1'b1;
        decode_resp.length = '0;
        exp_bip            = '0;
        exp_valid          = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #sample_delay;
        check_flag(packet_valid, 1'b0, "packet_valid after reset");
        check_bip(bip, '0, "bip after reset");
        check_flag(apb_resp.pslverr, 1'b0, "pslverr after reset");

        test_fill_status();
        test_extraction();
        test_partial();
        test_advance();
        hold_decode();
        test_redirect_priority();

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire
